/* source/loader_pkg.sv */
package loader_pkg;

	// one byte as it arrives over SPI
	typedef logic [7:0] byte_t;

	// memory data word
	typedef logic [31:0] word_t;

	// byte address on the memory port, bits 1:0 are zero on the port
	typedef logic [23:0] addr_t;

	// byte lanes of a word, lane 0 is bits 7:0
	typedef logic [3:0] sel_t;

	// first byte of a download frame
	localparam byte_t CMD_LOAD = 8'h54;

	// SPI frame parser
	typedef enum logic [1:0] {
		// waiting for the command byte
		ST_CMD,
		// three start address bytes, msb first
		ST_ADDR,
		// payload, four bytes per word, lsb first
		ST_DATA,
		// unknown command, ignore the rest of the frame
		ST_SKIP
	} spi_state_t;

endpackage

/* source/spi_loader.sv */
`timescale 1ns/1ps

module spi_loader (
	input  logic              clk_32m,
	input  logic              rst_n_i,
	input  logic              spi_sck_i,
	input  logic              spi_ss_n_i,
	input  logic              spi_mosi_i,
	output logic              ld_active_o,
	output logic              ld_we_o,
	output loader_pkg::addr_t ld_addr_o,
	output loader_pkg::word_t ld_data_o
);

	// spi lines brought into clk_32m, sck gets a third stage for edge detect
	logic [2:0] sck_sync;
	logic [1:0] ss_sync;
	logic [1:0] mosi_sync;
	logic       sck_rise;
	logic       frame_open;

	// parser control
	logic [2:0]             bit_cnt;
	logic [1:0]             byte_cnt;
	logic                   byte_done;
	loader_pkg::spi_state_t state;

	// payload
	loader_pkg::byte_t shift_q;
	logic [23:0]       word_q;
	loader_pkg::addr_t addr_q;

	always_ff @(posedge clk_32m or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sck_sync  <= 3'b000;
			ss_sync   <= 2'b11;
			mosi_sync <= 2'b00;
		end else begin
			sck_sync  <= {sck_sync[1:0], spi_sck_i};
			ss_sync   <= {ss_sync[0], spi_ss_n_i};
			mosi_sync <= {mosi_sync[0], spi_mosi_i};
		end
	end

	assign sck_rise   = sck_sync[1] & ~sck_sync[2];
	assign frame_open = ~ss_sync[1];

	always_ff @(posedge clk_32m or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ld_active_o <= 1'b0;
			ld_we_o     <= 1'b0;
			bit_cnt     <= 3'd0;
			byte_cnt    <= 2'd0;
			byte_done   <= 1'b0;
			state       <= loader_pkg::ST_CMD;
		end else begin
			ld_active_o <= frame_open;
			ld_we_o     <= 1'b0;
			byte_done   <= 1'b0;
			if (!frame_open) begin
				// frame end, start over with the next command byte
				bit_cnt  <= 3'd0;
				byte_cnt <= 2'd0;
				state    <= loader_pkg::ST_CMD;
			end else begin
				if (sck_rise) begin
					bit_cnt   <= bit_cnt + 3'd1;
					byte_done <= (bit_cnt == 3'd7);
				end
				if (byte_done) begin
					case (state)
						loader_pkg::ST_CMD: begin
							byte_cnt <= 2'd0;
							if (shift_q == loader_pkg::CMD_LOAD)
								state <= loader_pkg::ST_ADDR;
							else
								state <= loader_pkg::ST_SKIP;
						end
						loader_pkg::ST_ADDR: begin
							if (byte_cnt == 2'd2) begin
								byte_cnt <= 2'd0;
								state    <= loader_pkg::ST_DATA;
							end else begin
								byte_cnt <= byte_cnt + 2'd1;
							end
						end
						loader_pkg::ST_DATA: begin
							// wraps back to lane 0 after each word
							byte_cnt <= byte_cnt + 2'd1;
							if (byte_cnt == 2'd3)
								ld_we_o <= 1'b1;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk_32m) begin
		if (frame_open && sck_rise)
			shift_q <= {shift_q[6:0], mosi_sync[1]};
		if (frame_open && byte_done) begin
			case (state)
				loader_pkg::ST_ADDR: addr_q <= {addr_q[15:0], shift_q};
				loader_pkg::ST_DATA: begin
					case (byte_cnt)
						2'd0: word_q[7:0]   <= shift_q;
						2'd1: word_q[15:8]  <= shift_q;
						2'd2: word_q[23:16] <= shift_q;
						default: begin
							// last lane completes the word
							ld_data_o <= {shift_q, word_q};
							ld_addr_o <= addr_q;
							addr_q    <= addr_q + 24'd4;
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic              clk_32m,
	input  logic              rst_n_i,
	// loader side
	input  logic              ld_active_i,
	input  logic              ld_we_i,
	input  loader_pkg::addr_t ld_addr_i,
	input  loader_pkg::word_t ld_data_i,
	// core side, stb doubles as cyc
	input  logic              core_stb_i,
	input  logic              core_we_i,
	input  loader_pkg::sel_t  core_sel_i,
	input  loader_pkg::addr_t core_addr_i,
	input  loader_pkg::word_t core_wdata_i,
	// memory port
	input  logic              ram_ack_i,
	output logic              ram_stb_o,
	output logic              ram_we_o,
	output loader_pkg::sel_t  ram_sel_o,
	output loader_pkg::addr_t ram_addr_o,
	output loader_pkg::word_t ram_wdata_o,
	output logic              core_ack_o,
	output logic              core_rst_o
);

	logic loader_stb;
	logic ld_active_q;
	logic rom_ready;

	// loader strobe held from the word pulse until the memory acks
	always_ff @(posedge clk_32m or negedge rst_n_i) begin
		if (!rst_n_i) begin
			loader_stb <= 1'b0;
		end else if (ld_we_i) begin
			loader_stb <= 1'b1;
		end else if (ram_ack_i) begin
			loader_stb <= 1'b0;
		end
	end

	// rom_ready is sticky after the first download finishes
	always_ff @(posedge clk_32m or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ld_active_q <= 1'b0;
			rom_ready   <= 1'b0;
			core_rst_o  <= 1'b1;
		end else begin
			ld_active_q <= ld_active_i;
			if (ld_active_q && !ld_active_i)
				rom_ready <= 1'b1;
			// registered so the core sees a clean reset release
			core_rst_o <= ~rom_ready;
		end
	end

	// loader owns the port for the whole download
	assign ram_stb_o   = ld_active_i ? loader_stb : core_stb_i;
	assign ram_we_o    = ld_active_i ? 1'b1 : core_we_i;
	assign ram_sel_o   = ld_active_i ? 4'hf : core_sel_i;
	assign ram_addr_o  = ld_active_i ? {ld_addr_i[23:2], 2'b00} : {core_addr_i[23:2], 2'b00};
	assign ram_wdata_o = ld_active_i ? ld_data_i : core_wdata_i;

	// core never sees acks that belong to the loader
	assign core_ack_o = ld_active_i ? 1'b0 : ram_ack_i;

endmodule

/* source/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
	parameter int ADDR_W = 10
) (
	input  logic              clk_32m,
	input  logic              rst_n_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  loader_pkg::sel_t  sel_i,
	input  loader_pkg::addr_t addr_i,
	input  loader_pkg::word_t wdata_i,
	output logic              ack_o,
	output loader_pkg::word_t rdata_o
);

	loader_pkg::word_t mem [2**ADDR_W];

	logic [ADDR_W-1:0] word_idx;
	logic              access;

	// word index, upper address bits wrap
	assign word_idx = addr_i[ADDR_W+1:2];

	// a new access is a strobe that is not already being acked
	assign access = stb_i & ~ack_o;

	always_ff @(posedge clk_32m or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= access;
	end

	// write lands on the edge that raises ack
	always_ff @(posedge clk_32m) begin
		if (access && we_i) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (sel_i[lane])
					mem[word_idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
			end
		end
	end

	// read data valid together with ack
	always_ff @(posedge clk_32m) begin
		if (access)
			rdata_o <= mem[word_idx];
	end

endmodule

/* source/loader_top.sv */
`timescale 1ns/1ps

module loader_top #(
	parameter int ADDR_W = 10
) (
	input  logic              clk_32m,
	input  logic              rst_n_i,
	// host spi
	input  logic              spi_sck_i,
	input  logic              spi_ss_n_i,
	input  logic              spi_mosi_i,
	// core memory bus
	input  logic              core_stb_i,
	input  logic              core_we_i,
	input  loader_pkg::sel_t  core_sel_i,
	input  loader_pkg::addr_t core_addr_i,
	input  loader_pkg::word_t core_wdata_i,
	output logic              core_ack_o,
	output loader_pkg::word_t core_rdata_o,
	output logic              core_rst_o
);

	// loader to arbiter
	logic              ld_active;
	logic              ld_we;
	loader_pkg::addr_t ld_addr;
	loader_pkg::word_t ld_data;

	// arbiter to memory
	logic              ram_stb;
	logic              ram_we;
	loader_pkg::sel_t  ram_sel;
	loader_pkg::addr_t ram_addr;
	loader_pkg::word_t ram_wdata;
	logic              ram_ack;

	spi_loader i_spi_loader (
		.clk_32m     (clk_32m),
		.rst_n_i     (rst_n_i),
		.spi_sck_i   (spi_sck_i),
		.spi_ss_n_i  (spi_ss_n_i),
		.spi_mosi_i  (spi_mosi_i),
		.ld_active_o (ld_active),
		.ld_we_o     (ld_we),
		.ld_addr_o   (ld_addr),
		.ld_data_o   (ld_data)
	);

	mem_arbiter i_mem_arbiter (
		.clk_32m      (clk_32m),
		.rst_n_i      (rst_n_i),
		.ld_active_i  (ld_active),
		.ld_we_i      (ld_we),
		.ld_addr_i    (ld_addr),
		.ld_data_i    (ld_data),
		.core_stb_i   (core_stb_i),
		.core_we_i    (core_we_i),
		.core_sel_i   (core_sel_i),
		.core_addr_i  (core_addr_i),
		.core_wdata_i (core_wdata_i),
		.ram_ack_i    (ram_ack),
		.ram_stb_o    (ram_stb),
		.ram_we_o     (ram_we),
		.ram_sel_o    (ram_sel),
		.ram_addr_o   (ram_addr),
		.ram_wdata_o  (ram_wdata),
		.core_ack_o   (core_ack_o),
		.core_rst_o   (core_rst_o)
	);

	// read data goes straight back to the core
	wb_ram #(
		.ADDR_W (ADDR_W)
	) i_wb_ram (
		.clk_32m (clk_32m),
		.rst_n_i (rst_n_i),
		.stb_i   (ram_stb),
		.we_i    (ram_we),
		.sel_i   (ram_sel),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.ack_o   (ram_ack),
		.rdata_o (core_rdata_o)
	);

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
	parameter int HALF_NS      = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_32m,
	output logic rst_n_o
);

	initial begin
		clk_32m = 1'b0;
		forever #(HALF_NS) clk_32m = ~clk_32m;
	end

	// release just after an edge, same as the other stimulus
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_32m);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

/* tb/loader_assertions.sv */
`timescale 1ns/1ps

module loader_assertions (
	input logic clk_32m,
	input logic rst_n_i,
	input logic ld_active_i,
	input logic core_ack_i,
	input logic ram_stb_i,
	input logic ram_ack_i,
	input logic core_rst_i
);

	// failure tallies per rule
	int ack_fails = 0;
	int stb_fails = 0;
	int rst_fails = 0;

	// loader acks never leak to the core, not even in the cycle after the download ends
	a_core_ack_masked: assert property (
		@(posedge clk_32m) disable iff (!rst_n_i)
			(ld_active_i || $past(ld_active_i)) |-> !core_ack_i
	) else begin
		ack_fails++;
		$error("core ack high during or just after a download");
	end

	// a strobe is held until its ack
	a_stb_held: assert property (
		@(posedge clk_32m) disable iff (!rst_n_i) ram_stb_i && !ram_ack_i |=> ram_stb_i
	) else begin
		stb_fails++;
		$error("memory strobe dropped before its ack");
	end

	// once released the core stays out of reset
	a_rst_sticky: assert property (
		@(posedge clk_32m) disable iff (!rst_n_i) !core_rst_i |=> !core_rst_i
	) else begin
		rst_fails++;
		$error("core reset rose again after release");
	end

endmodule

bind mem_arbiter loader_assertions i_loader_assertions (
	.clk_32m     (clk_32m),
	.rst_n_i     (rst_n_i),
	.ld_active_i (ld_active_i),
	.core_ack_i  (core_ack_o),
	.ram_stb_i   (ram_stb_o),
	.ram_ack_i   (ram_ack_i),
	.core_rst_i  (core_rst_o)
);

/* tb/loader_tb.sv */
`timescale 1ns/1ps

module loader_tb;

	localparam int ADDR_W         = 10;
	localparam int RAM_WORDS      = 2**ADDR_W;
	localparam int TIMEOUT_CYCLES = 2000;

	logic              clk_32m;
	logic              rst_n_i;
	logic              spi_sck;
	logic              spi_ss_n;
	logic              spi_mosi;
	logic              core_stb;
	logic              core_we;
	loader_pkg::sel_t  core_sel;
	loader_pkg::addr_t core_addr;
	loader_pkg::word_t core_wdata;
	logic              core_ack;
	loader_pkg::word_t core_rdata;
	logic              core_rst;

	logic [31:0]       vec [0:1023];
	loader_pkg::word_t shadow [RAM_WORDS];
	loader_pkg::byte_t frame_q[$];
	loader_pkg::byte_t data_q[$];
	logic [31:0]       rng_state;
	int                error_count;
	int                check_count;
	int                limit_cycles;
	logic              frame_busy;
	logic              rst_released;

	clock_gen #(
		.HALF_NS      (4),
		.RESET_CYCLES (16)
	) i_clock_gen (
		.clk_32m (clk_32m),
		.rst_n_o (rst_n_i)
	);

	loader_top #(
		.ADDR_W (ADDR_W)
	) i_loader_top (
		.clk_32m      (clk_32m),
		.rst_n_i      (rst_n_i),
		.spi_sck_i    (spi_sck),
		.spi_ss_n_i   (spi_ss_n),
		.spi_mosi_i   (spi_mosi),
		.core_stb_i   (core_stb),
		.core_we_i    (core_we),
		.core_sel_i   (core_sel),
		.core_addr_i  (core_addr),
		.core_wdata_i (core_wdata),
		.core_ack_o   (core_ack),
		.core_rdata_o (core_rdata),
		.core_rst_o   (core_rst)
	);

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR %s", msg);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// word slot in the memory, upper address bits wrap
	function automatic int word_index(input loader_pkg::addr_t addr);
		return int'(addr[ADDR_W+1:2]);
	endfunction

	task automatic drive_slot();
		@(posedge clk_32m);
		#1;
	endtask

	// 8 clocks, 64 ns
	task automatic spi_half();
		repeat (8) @(posedge clk_32m);
		#1;
	endtask

	task automatic gap();
		repeat (16) @(posedge clk_32m);
		#1;
	endtask

	task automatic open_frame();
		drive_slot();
		spi_ss_n   = 1'b0;
		frame_busy = 1'b1;
		spi_half();
		spi_half();
	endtask

	// mode 0, msb first, then close the frame
	task automatic shift_frame();
		foreach (frame_q[i]) begin
			for (int b = 7; b >= 0; b--) begin
				spi_mosi = frame_q[i][b];
				spi_half();
				spi_sck = 1'b1;
				spi_half();
				spi_sck = 1'b0;
			end
		end
		spi_half();
		spi_ss_n   = 1'b1;
		frame_busy = 1'b0;
	endtask

	task automatic watch_frame();
		bit ack_seen = 1'b0;
		bit rst_moved = 1'b0;
		while (frame_busy) begin
			@(negedge clk_32m);
			if (core_ack === 1'b1 && !ack_seen) begin
				ack_seen = 1'b1;
				report_error("core ack seen while a download frame was open");
			end
			if (core_rst === rst_released && !rst_moved) begin
				rst_moved = 1'b1;
				report_error("core reset changed while a download frame was open");
			end
		end
	endtask

	task automatic transfer_frame();
		fork
			shift_frame();
			watch_frame();
		join
	endtask

	task automatic start_access(input logic we, input loader_pkg::addr_t addr,
			input loader_pkg::word_t wdata, input loader_pkg::sel_t sel);
		drive_slot();
		core_stb   = 1'b1;
		core_we    = we;
		core_sel   = sel;
		core_addr  = addr;
		core_wdata = wdata;
	endtask

	task automatic finish_access(output loader_pkg::word_t rdata, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_32m);
			cycles++;
		end while (core_ack !== 1'b1 && cycles < TIMEOUT_CYCLES);
		if (core_ack !== 1'b1)
			report_error("core access got no ack before the timeout");
		rdata = core_rdata;
		drive_slot();
		core_stb = 1'b0;
		core_we  = 1'b0;
	endtask

	task automatic core_access(input logic we, input loader_pkg::addr_t addr,
			input loader_pkg::word_t wdata, input loader_pkg::sel_t sel,
			output loader_pkg::word_t rdata);
		int cycles;
		start_access(we, addr, wdata, sel);
		finish_access(rdata, cycles);
		// sampled one cycle after the memory sees the strobe
		compare_value("core ack latency", 2, cycles);
	endtask

	// reset drops 2 cycles after ld_active falls
	task automatic release_check();
		int cycles = 0;
		while (i_loader_top.ld_active === 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk_32m);
			cycles++;
		end
		cycles = 0;
		do begin
			@(negedge clk_32m);
			cycles++;
		end while (core_rst !== 1'b0 && cycles < 50);
		compare_value("core reset release delay", 2, cycles);
		rst_released = 1'b1;
	endtask

	// full words little endian, a trailing partial word is dropped
	task automatic apply_load(input loader_pkg::addr_t addr);
		for (int w = 0; w < data_q.size() / 4; w++)
			shadow[word_index(addr + 24'(4 * w))] =
				{data_q[4*w+3], data_q[4*w+2], data_q[4*w+1], data_q[4*w]};
	endtask

	task automatic run_load(input loader_pkg::addr_t addr, input bit hold);
		loader_pkg::word_t rdata;
		int cycles;
		frame_q = {loader_pkg::CMD_LOAD, addr[23:16], addr[15:8], addr[7:0]};
		foreach (data_q[i])
			frame_q.push_back(data_q[i]);
		open_frame();
		// core asks for the first word while the loader owns the port
		if (hold)
			start_access(1'b0, addr, '0, 4'hf);
		transfer_frame();
		apply_load(addr);
		if (hold) begin
			fork
				begin
					finish_access(rdata, cycles);
					compare_value("read held during load", shadow[word_index(addr)], rdata);
				end
				release_check();
			join
		end else if (!rst_released) begin
			release_check();
		end
		gap();
	endtask

	initial begin
		int p;
		int op_end;
		int bits;
		int ops;
		int count;
		loader_pkg::addr_t addr;
		loader_pkg::word_t rdata;
		spi_sck      = 1'b0;
		spi_ss_n     = 1'b1;
		spi_mosi     = 1'b0;
		core_stb     = 1'b0;
		core_we      = 1'b0;
		core_sel     = '0;
		core_addr    = '0;
		core_wdata   = '0;
		frame_busy   = 1'b0;
		rst_released = 1'b0;
		rng_state    = 32'h9510bce6;
		error_count  = 0;
		check_count  = 0;
		limit_cycles = 0;
		$readmemh("tb/loader_vectors.txt", vec);

		// size the run for the watchdog
		p    = 0;
		bits = 0;
		ops  = 0;
		while (vec[p] !== 32'h0) begin
			count = int'(vec[p+2]);
			case (vec[p])
				32'h1, 32'h5: begin
					bits += 8 * (4 + count);
					p    += 3 + count;
				end
				32'h2: begin
					bits += 8 * (1 + count);
					p    += 3 + count;
				end
				32'h3: p += 4;
				32'h4: p += 3;
				32'h6: begin
					bits += 8 * (4 + count);
					p    += 3;
				end
				32'h7: p += 2;
				default: begin
					report_error($sformatf("unknown op %h at word %0d of the vectors", vec[p], p));
					break;
				end
			endcase
			ops++;
		end
		op_end       = p;
		limit_cycles = bits * 16 + (ops + 1) * 200;

		wait (rst_n_i === 1'b1);
		drive_slot();
		@(negedge clk_32m);
		compare_value("reset core_rst", 1, core_rst);
		compare_value("reset core_ack", 0, core_ack);
		compare_value("reset ld_we", 0, i_loader_top.ld_we);
		compare_value("reset ld_active", 0, i_loader_top.ld_active);
		compare_value("reset ram_stb", 0, i_loader_top.ram_stb);

		p = 0;
		while (p < op_end) begin
			addr  = vec[p+1][23:0];
			count = int'(vec[p+2]);
			data_q.delete();
			case (vec[p])
				32'h1, 32'h5: begin
					for (int i = 0; i < count; i++)
						data_q.push_back(vec[p+3+i][7:0]);
					run_load(addr, vec[p] == 32'h5);
					p += 3 + count;
				end
				32'h2: begin
					frame_q = {vec[p+1][7:0]};
					for (int i = 0; i < count; i++)
						frame_q.push_back(vec[p+3+i][7:0]);
					open_frame();
					transfer_frame();
					gap();
					p += 3 + count;
				end
				32'h3: begin
					core_access(1'b1, addr, vec[p+2], vec[p+3][3:0], rdata);
					for (int l = 0; l < 4; l++)
						if (vec[p+3][l])
							shadow[word_index(addr)][l*8 +: 8] = vec[p+2][l*8 +: 8];
					p += 4;
				end
				32'h4: begin
					core_access(1'b0, addr, '0, 4'hf, rdata);
					compare_value($sformatf("read %06h", addr), vec[p+2], rdata);
					compare_value($sformatf("shadow %06h", addr), shadow[word_index(addr)], rdata);
					p += 3;
				end
				32'h6: begin
					for (int i = 0; i < count; i++) begin
						rng_state = xorshift(rng_state);
						data_q.push_back(rng_state[7:0]);
					end
					run_load(addr, 1'b0);
					p += 3;
				end
				default: begin
					core_access(1'b0, addr, '0, 4'hf, rdata);
					compare_value($sformatf("shadow %06h", addr), shadow[word_index(addr)], rdata);
					p += 2;
				end
			endcase
		end

		repeat (8) @(posedge clk_32m);
		error_count += i_loader_top.i_mem_arbiter.i_loader_assertions.ack_fails;
		error_count += i_loader_top.i_mem_arbiter.i_loader_assertions.stb_fails;
		error_count += i_loader_top.i_mem_arbiter.i_loader_assertions.rst_fails;
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_32m);
		$display("watchdog expired after %0d cycles, the tests did not finish", limit_cycles);
		$display("sim failed");
		$finish;
	end

endmodule

/* tb/loader_vectors.txt */
// op then fields in hex; 00 ends the list
// 05 load with core read held: addr count bytes | 01 load: addr count bytes
// 02 other command: cmd count bytes | 03 core write: addr data sel
// 04 core read: addr expected | 06 random load: addr count | 07 read vs shadow: addr
05 000100 00000008 11 22 33 44 55 66 77 88
04 000100 44332211
04 000104 88776655
// trailing partial word leaves 208 alone
03 000208 cafef00d f
01 000200 0000000a a0 a1 a2 a3 b0 b1 b2 b3 c0 c1
04 000200 a3a2a1a0
04 000204 b3b2b1b0
04 000208 cafef00d
// partial lane writes
03 000100 deadbeef 3
04 000100 4433beef
03 000104 01020304 c
04 000104 01026655
03 000204 ffffffff 5
04 000204 b3ffb1ff
03 000200 12345678 8
04 000200 12a2a1a0
03 000208 00000000 2
04 000208 cafe000d
// low address bits and high bits wrap
04 000102 4433beef
04 001100 4433beef
// frames with other commands write nothing
02 55 00000007 00 01 00 99 99 99 99
04 000100 4433beef
02 00 00000004 00 02 00 00
04 000200 12a2a1a0
// second load with the core running
01 000300 0000000c 01 02 03 04 05 06 07 08 09 0a 0b 0c
04 000300 04030201
04 000304 08070605
04 000308 0c0b0a09
01 000104 00000004 ee dd cc bb
04 000104 bbccddee
04 000100 4433beef
// random payloads
06 000400 00000010
07 000400
07 000404
07 000408
07 00040c
03 000504 5a5a5a5a f
06 000500 00000006
07 000500
07 000504
00

/* list.f */
source/loader_pkg.sv
source/spi_loader.sv
source/mem_arbiter.sv
source/wb_ram.sv
source/loader_top.sv
tb/clock_gen.sv
tb/loader_assertions.sv
tb/loader_tb.sv

/* Makefile */
TOP := loader_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "sim passed" $(LOG)

obj_dir/V$(TOP): list.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --top-module loader_top -f list.f

clean:
	rm -rf obj_dir $(LOG)
